/* list.f */
+incdir+logic
logic/bp_pkg.sv
logic/bp_target_buffer.sv
logic/bp_gshare.sv
logic/bp_regs.sv
logic/branch_predictor.sv
tests/bp_checker.sv
tests/bp_tb.sv

/* Makefile */
# Verilator build for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= bp_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
FLAGS     ?= --binary --timing --assert -j 0

BIN := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard logic/*.sv logic/*.svh tests/*.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

/* tests/bp_tb.sv */
// Branch predictor testbench
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_tb;

    logic                clk;
    logic                rst_i;
    bp_pkg::lookup_t     lookup_i;
    bp_pkg::prediction_t prediction_o;
    bp_pkg::resolve_t    resolve_i;
    bp_pkg::apb_req_t    apb_i;
    bp_pkg::apb_rsp_t    apb_o;

    // Reference model state ----------------------------
    logic           m_valid  [`BP_BTB_ENTRIES];
    logic [24:0]    m_tag    [`BP_BTB_ENTRIES];
    logic [31:0]    m_target [`BP_BTB_ENTRIES];
    logic           m_jump   [`BP_BTB_ENTRIES];
    logic           m_branch [`BP_BTB_ENTRIES];
    logic [1:0]     m_pht    [1 << `BP_GHR_BITS];
    logic [4:0]     m_ghr;
    logic           m_enable;
    logic [31:0]    m_resolved;
    logic [31:0]    m_mispred;
    logic [15:0]    lfsr;
    int             cycles;
    int             errors;

    branch_predictor dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic bp_pkg::prediction_t ref_predict(input logic [31:0] pc);
        bp_pkg::prediction_t p;
        logic [4:0]          idx;
        idx         = pc[6:2];
        p.pht_index = pc[6:2] ^ m_ghr;
        p.hit       = m_enable && m_valid[idx] && (m_tag[idx] == pc[31:7]);
        p.taken     = p.hit && (m_jump[idx] || (m_branch[idx] && m_pht[p.pht_index][1]));
        p.target    = m_target[idx];
        return p;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // Compare, then apply the inputs that the next edge will take.
    always @(negedge clk) begin
        bp_pkg::prediction_t exp;
        logic                is_jump;
        logic                is_br;
        logic                wr_en;
        logic [4:0]          idx;
        if (rst_i) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) m_valid[i] = 1'b0;
            for (int i = 0; i < (1 << `BP_GHR_BITS); i++) m_pht[i] = 2'b01;
            m_ghr = '0;
            m_enable = 1'b1;
            m_resolved = '0;
            m_mispred = '0;
        end else begin
            exp     = ref_predict(lookup_i.pc);
            is_jump = (resolve_i.opcode == `BP_OP_JAL) || (resolve_i.opcode == `BP_OP_JALR);
            is_br   = resolve_i.opcode == `BP_OP_BRANCH;
            wr_en   = resolve_i.valid && (is_jump || (is_br && resolve_i.taken));
            idx     = resolve_i.pc[6:2];
            if (wr_en && (idx == lookup_i.pc[6:2])) exp.target = resolve_i.target;
            check("hit", prediction_o.hit, exp.hit);
            check("taken", prediction_o.taken, exp.taken);
            check("pht_index", prediction_o.pht_index, exp.pht_index);
            if (exp.hit || (wr_en && (idx == lookup_i.pc[6:2])))
                check("target", prediction_o.target, exp.target);
            if (!(apb_i.psel && apb_i.penable)) check("idle prdata", apb_o.prdata, 32'd0);
            if (wr_en) begin
                m_valid[idx]  = 1'b1;
                m_tag[idx]    = resolve_i.pc[31:7];
                m_target[idx] = resolve_i.target;
                m_jump[idx]   = is_jump;
                m_branch[idx] = is_br;
            end
            if (resolve_i.valid && is_br) begin
                if (resolve_i.taken && m_pht[resolve_i.pht_index] != 2'b11)
                    m_pht[resolve_i.pht_index]++;
                else if (!resolve_i.taken && m_pht[resolve_i.pht_index] != 2'b00)
                    m_pht[resolve_i.pht_index]--;
                m_ghr = {m_ghr[3:0], resolve_i.taken};
                m_resolved++;
                if (resolve_i.taken != resolve_i.predicted_taken) m_mispred++;
            end
            if (apb_i.psel && apb_i.penable && apb_i.pwrite) begin
                case (apb_i.paddr)
                    `BP_ADDR_CTRL: begin
                        m_enable = apb_i.pwdata[0];
                        if (apb_i.pwdata[1]) m_ghr = '0;
                    end
                    `BP_ADDR_RESOLVED: m_resolved = '0;
                    `BP_ADDR_MISPRED:  m_mispred = '0;
                    default: ;
                endcase
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("Timeout: the run went past its cycle limit");
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    // Stimulus -----------------------------------------
    task automatic step(input logic [31:0] pc, input logic [6:0] op, input logic tk,
                        input logic [31:0] tgt, input logic vld);
        bp_pkg::resolve_t    r;
        bp_pkg::prediction_t p;
        @(posedge clk);
        p                 = ref_predict(pc);
        r.valid           = vld;
        r.pc              = pc;
        r.opcode          = op;
        r.target          = tgt;
        r.taken           = tk;
        r.predicted_taken = p.taken;
        r.pht_index       = pc[6:2] ^ m_ghr;
        lookup_i.pc <= pc;
        resolve_i   <= r;
    endtask

    task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                              input logic [31:0] exp_data, input logic exp_err);
        @(posedge clk);
        resolve_i <= '0;
        apb_i     <= {1'b1, 1'b0, wr, addr, wdata};
        @(posedge clk);
        apb_i.penable <= 1'b1;
        @(negedge clk);
        if (!wr) check("prdata", apb_o.prdata, exp_data);
        check("pslverr", apb_o.pslverr, exp_err);
        @(posedge clk);
        apb_i <= '0;
    endtask

    function automatic logic [31:0] rand_pc();
        return 32'h0000_1000 | (rand_bits(2) << 7) | (rand_bits(5) << 2);
    endfunction

    initial begin
        logic [31:0] pc;
        logic [1:0]  sel;
        lfsr = 16'd98;
        cycles = 0;
        errors = 0;
        rst_i = 1'b1;
        lookup_i = '0;
        resolve_i = '0;
        apb_i = '0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;

        for (int i = 0; i < 20; i++) step(rand_pc(), 7'h13, 1'b0, '0, 1'b0);
        apb_access(`BP_ADDR_GHR, 1'b0, '0, 32'd0, 1'b0);
        apb_access(`BP_ADDR_RESOLVED, 1'b0, '0, 32'd0, 1'b0);
        apb_access(`BP_ADDR_MISPRED, 1'b0, '0, 32'd0, 1'b0);
        apb_access(`BP_ADDR_CTRL, 1'b0, '0, 32'd1, 1'b0);

        // Taken JAL, then an alias with another tag.
        step(32'h0000_2044, `BP_OP_JAL, 1'b1, 32'h0000_3000, 1'b1);
        step(32'h0000_2044, 7'h13, 1'b0, '0, 1'b0);
        @(negedge clk);
        check("jal hit", prediction_o.hit, 1'b1);
        check("jal taken", prediction_o.taken, 1'b1);
        check("jal target", prediction_o.target, 32'h0000_3000);
        step(32'h0000_20C4, 7'h13, 1'b0, '0, 1'b0);
        @(negedge clk);
        check("alias hit", prediction_o.hit, 1'b0);

        // Walk one branch counter up to saturation and back down.
        for (int i = 0; i < 10; i++) step(32'h0000_4010, `BP_OP_BRANCH, 1'b1, 32'h4100, 1'b1);
        for (int i = 0; i < 10; i++) step(32'h0000_4010, `BP_OP_BRANCH, 1'b0, 32'h4100, 1'b1);
        step(32'h0000_4010, 7'h13, 1'b0, '0, 1'b0);

        for (int i = 0; i < 1500; i++) begin
            pc  = rand_pc();
            sel = rand_bits(2);
            case (sel)
                2'd0, 2'd1: step(pc, `BP_OP_BRANCH, rand_bits(1), rand_pc(), rand_bits(1));
                2'd2:       step(pc, `BP_OP_JAL, 1'b1, rand_pc(), rand_bits(1));
                default:    step(pc, 7'h13, 1'b0, '0, rand_bits(1));
            endcase
        end
        step(rand_pc(), 7'h13, 1'b0, '0, 1'b0);
        apb_access(`BP_ADDR_RESOLVED, 1'b0, '0, m_resolved, 1'b0);
        apb_access(`BP_ADDR_MISPRED, 1'b0, '0, m_mispred, 1'b0);

        apb_access(`BP_ADDR_CTRL, 1'b1, 32'd0, '0, 1'b0);
        for (int i = 0; i < 20; i++) step(rand_pc(), 7'h13, 1'b0, '0, 1'b0);
        apb_access(`BP_ADDR_CTRL, 1'b1, 32'd1, '0, 1'b0);
        for (int i = 0; i < 20; i++) step(rand_pc(), 7'h13, 1'b0, '0, 1'b0);
        step(32'h0000_4010, `BP_OP_BRANCH, 1'b1, 32'h0000_4100, 1'b1);
        step(32'h0000_4010, 7'h13, 1'b0, '0, 1'b0);
        apb_access(`BP_ADDR_GHR, 1'b0, '0, m_ghr, 1'b0);
        apb_access(`BP_ADDR_CTRL, 1'b1, 32'd3, '0, 1'b0);
        apb_access(`BP_ADDR_GHR, 1'b0, '0, 32'd0, 1'b0);
        apb_access(`BP_ADDR_RESOLVED, 1'b1, 32'd5, '0, 1'b0);
        apb_access(`BP_ADDR_RESOLVED, 1'b0, '0, 32'd0, 1'b0);
        apb_access(8'h10, 1'b0, '0, 32'd0, 1'b1);
        repeat (2) @(posedge clk);

        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "errors found");
        end
    end

endmodule

`default_nettype wire

/* tests/bp_checker.sv */
// Predictor assertions
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_checker (
    input wire                  clk,
    input wire                  rst_i,
    input bp_pkg::prediction_t  prediction_o,
    input bp_pkg::apb_req_t     apb_i,
    input bp_pkg::apb_rsp_t     apb_o,
    input wire                  enable
);

    logic mapped;

    assign mapped = (apb_i.paddr == `BP_ADDR_CTRL) || (apb_i.paddr == `BP_ADDR_GHR) ||
                    (apb_i.paddr == `BP_ADDR_RESOLVED) || (apb_i.paddr == `BP_ADDR_MISPRED);

    a_taken_hit: assert property (@(posedge clk) disable iff (rst_i)
        prediction_o.taken |-> prediction_o.hit)
        else $error("taken predicted without a hit");

    a_pready: assert property (@(posedge clk) disable iff (rst_i) apb_o.pready)
        else $error("pready dropped");

    // Errors only for an access to a hole in the map.
    a_slverr: assert property (@(posedge clk) disable iff (rst_i)
        apb_o.pslverr |-> (apb_i.psel && apb_i.penable && !mapped))
        else $error("pslverr outside an unmapped access");

    a_disabled: assert property (@(posedge clk) disable iff (rst_i)
        !enable |-> !prediction_o.hit)
        else $error("hit while prediction is disabled");

endmodule

bind branch_predictor bp_checker u_checker (
    .clk(clk), .rst_i(rst_i), .prediction_o(prediction_o),
    .apb_i(apb_i), .apb_o(apb_o), .enable(enable)
);

`default_nettype wire

/* logic/branch_predictor.sv */
// Branch predictor top level
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  wire                  clk,
    input  wire                  rst_i,
    input  bp_pkg::lookup_t      lookup_i,
    output bp_pkg::prediction_t  prediction_o,
    input  bp_pkg::resolve_t     resolve_i,
    input  bp_pkg::apb_req_t     apb_i,
    output bp_pkg::apb_rsp_t     apb_o
);

    logic         enable;
    logic         ghr_clear;
    logic         btb_hit;
    logic         btb_jump;
    logic         btb_branch;
    logic         gs_taken;
    bp_pkg::pc_t  btb_target;
    bp_pkg::ghr_t gs_index;
    bp_pkg::ghr_t ghr;

    // Blocks -------------------------------------------
    bp_target_buffer u_btb (
        .clk(clk), .rst_i(rst_i), .lookup_i(lookup_i), .resolve_i(resolve_i),
        .enable_i(enable), .hit_o(btb_hit), .target_o(btb_target),
        .is_jump_o(btb_jump), .is_branch_o(btb_branch)
    );

    bp_gshare u_gshare (
        .clk(clk), .rst_i(rst_i), .lookup_i(lookup_i), .resolve_i(resolve_i),
        .ghr_clear_i(ghr_clear), .taken_o(gs_taken), .pht_index_o(gs_index), .ghr_o(ghr)
    );

    bp_regs u_regs (
        .clk(clk), .rst_i(rst_i), .apb_i(apb_i), .apb_o(apb_o), .resolve_i(resolve_i),
        .ghr_i(ghr), .enable_o(enable), .ghr_clear_o(ghr_clear)
    );

    // Jumps are always taken; branches follow gshare.
    assign prediction_o.hit       = btb_hit;
    assign prediction_o.taken     = btb_hit && (btb_jump || (btb_branch && gs_taken));
    assign prediction_o.target    = btb_target;
    assign prediction_o.pht_index = gs_index;

endmodule

`default_nettype wire

/* logic/bp_regs.sv */
// Predictor APB registers
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_regs (
    input  wire               clk,
    input  wire               rst_i,
    input  bp_pkg::apb_req_t  apb_i,
    output bp_pkg::apb_rsp_t  apb_o,
    input  bp_pkg::resolve_t  resolve_i,
    input  bp_pkg::ghr_t      ghr_i,
    output logic              enable_o,
    output logic              ghr_clear_o
);

    logic           access;
    logic           wr;
    logic           rd;
    logic           mapped;
    logic           br_valid;
    logic           br_miss;
    logic           enable_q;
    bp_pkg::count_t resolved_q;
    bp_pkg::count_t mispred_q;
    logic [31:0]    rd_data;

    // Decode -------------------------------------------
    assign access = apb_i.psel && apb_i.penable;           // Access phase.
    assign wr     = access && apb_i.pwrite;
    assign rd     = access && !apb_i.pwrite;
    assign mapped = (apb_i.paddr == `BP_ADDR_CTRL) || (apb_i.paddr == `BP_ADDR_GHR) ||
                    (apb_i.paddr == `BP_ADDR_RESOLVED) || (apb_i.paddr == `BP_ADDR_MISPRED);

    assign br_valid = resolve_i.valid && (resolve_i.opcode == `BP_OP_BRANCH);
    assign br_miss  = br_valid && (resolve_i.taken != resolve_i.predicted_taken);

    assign enable_o    = enable_q;
    assign ghr_clear_o = wr && (apb_i.paddr == `BP_ADDR_CTRL) && apb_i.pwdata[1];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            enable_q   <= 1'b1;
            resolved_q <= '0;
            mispred_q  <= '0;
        end else begin
            if (wr && (apb_i.paddr == `BP_ADDR_CTRL)) begin
                enable_q <= apb_i.pwdata[0];
            end
            // A write clears the counter and drops any same-cycle event.
            if (wr && (apb_i.paddr == `BP_ADDR_RESOLVED)) begin
                resolved_q <= '0;
            end else if (br_valid) begin
                resolved_q <= resolved_q + 32'd1;
            end
            if (wr && (apb_i.paddr == `BP_ADDR_MISPRED)) begin
                mispred_q <= '0;
            end else if (br_miss) begin
                mispred_q <= mispred_q + 32'd1;
            end
        end
    end

    // Read path ----------------------------------------
    always_comb begin
        case (apb_i.paddr)
            `BP_ADDR_CTRL:     rd_data = {31'd0, enable_q};  // Clear bit reads as 0.
            `BP_ADDR_GHR:      rd_data = {{(32-`BP_GHR_BITS){1'b0}}, ghr_i};
            `BP_ADDR_RESOLVED: rd_data = resolved_q;
            `BP_ADDR_MISPRED:  rd_data = mispred_q;
            default:           rd_data = '0;
        endcase
    end

    assign apb_o.prdata  = rd ? rd_data : 32'd0;
    assign apb_o.pready  = 1'b1;                             // No wait states.
    assign apb_o.pslverr = access && !mapped;

endmodule

`default_nettype wire

/* logic/bp_gshare.sv */
// Gshare direction predictor
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_gshare (
    input  wire               clk,
    input  wire               rst_i,
    input  bp_pkg::lookup_t   lookup_i,
    input  bp_pkg::resolve_t  resolve_i,
    input  wire               ghr_clear_i,
    output logic              taken_o,
    output bp_pkg::ghr_t      pht_index_o,
    output bp_pkg::ghr_t      ghr_o
);

    localparam int PHT_ENTRIES = 1 << `BP_GHR_BITS;

    logic [1:0]   pht_q [PHT_ENTRIES];
    bp_pkg::ghr_t ghr_q;
    logic         br_update;
    logic [1:0]   cnt_cur;

    // Lookup -------------------------------------------
    assign pht_index_o = lookup_i.pc[`BP_GHR_BITS+1:2] ^ ghr_q;
    assign taken_o     = pht_q[pht_index_o][1];        // Upper bit is the direction.
    assign ghr_o       = ghr_q;

    // Update -------------------------------------------
    assign br_update = resolve_i.valid && (resolve_i.opcode == `BP_OP_BRANCH);
    assign cnt_cur   = pht_q[resolve_i.pht_index];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= 2'b01;                      // Weakly not taken.
            end
        end else if (br_update) begin
            if (resolve_i.taken && (cnt_cur != 2'b11)) begin
                pht_q[resolve_i.pht_index] <= cnt_cur + 2'b01;
            end else if (!resolve_i.taken && (cnt_cur != 2'b00)) begin
                pht_q[resolve_i.pht_index] <= cnt_cur - 2'b01;
            end
        end
    end

    // A clear from the register block wins over a shift in the same cycle.
    always_ff @(posedge clk) begin
        if (rst_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (br_update) begin
            ghr_q <= {ghr_q[`BP_GHR_BITS-2:0], resolve_i.taken};
        end
    end

endmodule

`default_nettype wire

/* logic/bp_target_buffer.sv */
// Branch target buffer
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_target_buffer (
    input  wire               clk,
    input  wire               rst_i,
    input  bp_pkg::lookup_t   lookup_i,
    input  bp_pkg::resolve_t  resolve_i,
    input  wire               enable_i,
    output logic              hit_o,
    output bp_pkg::pc_t       target_o,
    output logic              is_jump_o,
    output logic              is_branch_o
);

    logic [`BP_BTB_ENTRIES-1:0] valid_q;
    bp_pkg::btb_tag_t           tag_mem    [`BP_BTB_ENTRIES];
    bp_pkg::pc_t                target_mem [`BP_BTB_ENTRIES];
    logic                       jump_mem   [`BP_BTB_ENTRIES];
    logic                       branch_mem [`BP_BTB_ENTRIES];

    bp_pkg::btb_idx_t lk_idx;
    bp_pkg::btb_tag_t lk_tag;
    bp_pkg::btb_idx_t wr_idx;
    bp_pkg::btb_tag_t wr_tag;
    logic             wr_jump;
    logic             wr_branch;
    logic             wr_en;

    // Write side ---------------------------------------
    assign wr_idx    = resolve_i.pc[`BP_BTB_IDX_BITS+1:2];
    assign wr_tag    = resolve_i.pc[31:`BP_BTB_IDX_BITS+2];
    assign wr_jump   = (resolve_i.opcode == `BP_OP_JAL) || (resolve_i.opcode == `BP_OP_JALR);
    assign wr_branch = (resolve_i.opcode == `BP_OP_BRANCH);
    // Only taken control flow allocates an entry.
    assign wr_en     = resolve_i.valid && (wr_jump || (wr_branch && resolve_i.taken));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= resolve_i.target;
            jump_mem[wr_idx]   <= wr_jump;
            branch_mem[wr_idx] <= wr_branch;
        end
    end

    // Lookup side --------------------------------------
    assign lk_idx = lookup_i.pc[`BP_BTB_IDX_BITS+1:2];
    assign lk_tag = lookup_i.pc[31:`BP_BTB_IDX_BITS+2];

    always_comb begin
        hit_o       = enable_i && valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
        target_o    = target_mem[lk_idx];
        is_jump_o   = jump_mem[lk_idx];
        is_branch_o = branch_mem[lk_idx];
        if (wr_en && (wr_idx == lk_idx)) begin
            target_o = resolve_i.target;                  // Same-cycle write bypass.
        end
    end

endmodule

`default_nettype wire

/* logic/bp_pkg.sv */
// Branch predictor types
`default_nettype none
`include "bp_params.svh"

package bp_pkg;

    typedef logic [31:0]                        pc_t;
    typedef logic [`BP_BTB_IDX_BITS-1:0]        btb_idx_t;
    typedef logic [31-`BP_BTB_IDX_BITS-2:0]     btb_tag_t;  // PC bits above the index.
    typedef logic [`BP_GHR_BITS-1:0]            ghr_t;      // Also the counter table index.
    typedef logic [6:0]                         opcode_t;
    typedef logic [31:0]                        count_t;

    typedef struct packed { pc_t pc; } lookup_t;

    typedef struct packed {
        logic  hit;
        logic  taken;
        pc_t   target;
        ghr_t  pht_index;
    } prediction_t;

    typedef struct packed {
        logic    valid;
        pc_t     pc;
        opcode_t opcode;
        pc_t     target;           // Actual target from execute.
        logic    taken;            // Actual direction.
        logic    predicted_taken;
        ghr_t    pht_index;        // Index used when the prediction was made.
    } resolve_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* logic/bp_params.svh */
// Branch predictor parameters
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// Table sizes --------------------------------------
`define BP_BTB_ENTRIES   32
`define BP_BTB_IDX_BITS  5
`define BP_GHR_BITS      5

// APB word offsets ---------------------------------
`define BP_ADDR_CTRL     8'h00
`define BP_ADDR_GHR      8'h04
`define BP_ADDR_RESOLVED 8'h08
`define BP_ADDR_MISPRED  8'h0C

`define BP_OP_BRANCH     7'b1100011
`define BP_OP_JAL        7'b1101111
`define BP_OP_JALR       7'b1100111
`endif
